// File: Makefile
# acquisition channel, Verilator flow
TOP := tb_acq_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f sim.f --top-module acq_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// File: logic/acq_pkg.sv
//////////////////////////////////////////////////////////////////////
// acquisition channel package
// shared widths of the pin word, sample, gain and time stamp
// calibration, stamped sample and output record structs
//////////////////////////////////////////////////////////////////////

package acq_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // calibrated sample width
  localparam int unsigned adc_w = 14;
  // raw word on the ADC pins, two low bits reserved
  localparam int unsigned pin_w = 16;
  // gain multiplier width
  localparam int unsigned gain_w = 16;
  // time stamp counter width
  localparam int unsigned ts_w = 64;

  // gain value for a factor of 1.0
  localparam int unsigned gain_one = 2**14;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // signed sample, before and after calibration
  typedef logic signed [adc_w-1:0] sample_t;
  // signed gain, fixed point with gain_one as unity
  typedef logic signed [gain_w-1:0] gain_t;

  // per channel calibration
  typedef struct packed {
    gain_t   gain;
    sample_t offset;
  } cal_t;

  // adc_clk cycle count
  typedef logic [ts_w-1:0] ts_t;

  // producer output, also the FIFO entry
  typedef struct packed {
    sample_t sample;
    ts_t     ts;
  } stamped_t;

  // one averaged output record
  typedef struct packed {
    sample_t avg;
    ts_t     ts;
  } rec_t;

endpackage: acq_pkg

// File: logic/acq_top.sv
//////////////////////////////////////////////////////////////////////
// acquisition channel top level
// front end, sample FIFO and averaging decimator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module acq_top import acq_pkg::*; #(
  parameter int unsigned fifo_depth  = 16,
  parameter int unsigned max_dec_log = 3
)(
  // clock and reset
  input  logic             adc_clk,
  input  logic             top_rst,
  // ADC pins
  input  logic [pin_w-1:0] adc_dat_i,
  input  logic             adc_vld_i,
  // configuration
  input  cal_t             cal_i,
  input  logic [1:0]       dec_i,
  // record stream
  output rec_t             rec_o,
  output logic             rec_vld_o,
  input  logic             rec_rdy_i,
  // status
  output logic             overflow_o
);

  // front end to FIFO
  stamped_t smp;
  logic     smp_vld;
  // FIFO to decimator
  stamped_t head;
  logic     head_vld;
  logic     head_rdy;

  adc_frontend frontend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .adc_vld_i (adc_vld_i),
    .cal_i     (cal_i),
    .smp_o     (smp),
    .smp_vld_o (smp_vld)
  );

  sample_fifo #(
    .fifo_depth (fifo_depth)
  ) buffer (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .wr_i       (smp),
    .wr_vld_i   (smp_vld),
    .rd_o       (head),
    .rd_vld_o   (head_vld),
    .rd_rdy_i   (head_rdy),
    .overflow_o (overflow_o)
  );

  sample_decimator #(
    .max_dec_log (max_dec_log)
  ) decimator (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dec_i     (dec_i),
    .smp_i     (head),
    .smp_vld_i (head_vld),
    .smp_rdy_o (head_rdy),
    .rec_o     (rec_o),
    .rec_vld_o (rec_vld_o),
    .rec_rdy_i (rec_rdy_i)
  );

endmodule: acq_top

// File: logic/adc_frontend.sv
//////////////////////////////////////////////////////////////////////
// ADC front end of the acquisition channel
// pin word capture and current time stamp counter
// offset binary to signed conversion
// gain and offset calibration with saturation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module adc_frontend import acq_pkg::*; (
  // clock and reset
  input  logic             adc_clk,
  input  logic             top_rst,
  // ADC pins
  input  logic [pin_w-1:0] adc_dat_i,
  input  logic             adc_vld_i,
  // calibration
  input  cal_t             cal_i,
  // stamped sample toward the FIFO, push only
  output stamped_t         smp_o,
  output logic             smp_vld_o
);

  // product width, sample times gain
  localparam int unsigned mul_w = adc_w + gain_w;
  // fixed point position of the gain
  localparam int unsigned gain_sh = $clog2(gain_one);

  // saturation limits, in product width
  localparam logic signed [mul_w-1:0] smp_max = mul_w'(2**(adc_w-1) - 1);
  localparam logic signed [mul_w-1:0] smp_min = -mul_w'(2**(adc_w-1));

  //////////////////////////////////////////////////////////////////////
  // current time stamp
  //////////////////////////////////////////////////////////////////////

  ts_t cts_q;

  // zero on the first edge after reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cts_q <= '0;
    end else begin
      cts_q <= cts_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 1, pin capture
  //////////////////////////////////////////////////////////////////////

  // reserved low bits are not kept
  logic [pin_w-1:2] pin_q;
  logic             pin_vld_q;
  ts_t              pin_ts_q;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      pin_vld_q <= 1'b0;
    end else begin
      pin_vld_q <= adc_vld_i;
    end
  end

  // payload, taken on every capture edge
  always_ff @(posedge adc_clk) begin
    if (adc_vld_i) begin
      pin_q    <= adc_dat_i[pin_w-1:2];
      pin_ts_q <= cts_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, conversion and calibration
  //////////////////////////////////////////////////////////////////////

  sample_t                  raw_smp;
  logic signed [mul_w-1:0]  prod;
  logic signed [mul_w-1:0]  scaled;
  logic signed [mul_w-1:0]  sum;
  logic signed [mul_w-1:0]  sat;

  // pins are inverted offset binary, msb kept as sign
  assign raw_smp = {pin_q[pin_w-1], ~pin_q[pin_w-2:2]};

  always_comb begin
    // full precision product
    prod   = raw_smp * cal_i.gain;
    // back to sample scale
    scaled = prod >>> gain_sh;
    // offset is sign extended by the signed add
    sum    = scaled + cal_i.offset;
    // clamp to the sample range
    if (sum > smp_max) begin
      sat = smp_max;
    end else if (sum < smp_min) begin
      sat = smp_min;
    end else begin
      sat = sum;
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_vld_o <= 1'b0;
    end else begin
      smp_vld_o <= pin_vld_q;
    end
  end

  // stamped sample, ts follows its word
  always_ff @(posedge adc_clk) begin
    if (pin_vld_q) begin
      smp_o.sample <= sat[adc_w-1:0];
      smp_o.ts     <= pin_ts_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // each capture is pushed two cycles later with its own stamp
  a_push_stamp: assert property (@(posedge adc_clk) disable iff (top_rst)
    adc_vld_i |-> ##2 smp_vld_o && (smp_o.ts == $past(cts_q, 2)));

endmodule: adc_frontend

// File: logic/sample_decimator.sv
//////////////////////////////////////////////////////////////////////
// averaging decimator
// sums groups of 2^dec samples, shifts the sum down
// one record per group, stamped with the first sample
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sample_decimator import acq_pkg::*; #(
  // largest decimation shift
  parameter int unsigned max_dec_log = 3
)(
  // clock and reset
  input  logic       adc_clk,
  input  logic       top_rst,
  // decimation shift, group of 2^dec_i samples
  input  logic [1:0] dec_i,
  // samples from the FIFO
  input  stamped_t   smp_i,
  input  logic       smp_vld_i,
  output logic       smp_rdy_o,
  // records out
  output rec_t       rec_o,
  output logic       rec_vld_o,
  input  logic       rec_rdy_i
);

  // sum of a full group never wraps
  localparam int unsigned acc_w = adc_w + max_dec_log;
  localparam int unsigned cnt_w = max_dec_log + 1;

  logic signed [acc_w-1:0] acc_q;
  logic signed [acc_w-1:0] acc_nxt;
  logic signed [acc_w-1:0] avg_wide;
  logic [cnt_w-1:0]        cnt_q;
  logic [cnt_w-1:0]        grp_last;
  ts_t                     ts_q;
  logic                    take;
  logic                    first;
  logic                    last;

  // stalled while a record waits, free when it leaves this cycle
  assign smp_rdy_o = !rec_vld_o || rec_rdy_i;
  assign take      = smp_vld_i && smp_rdy_o;

  // group position
  assign grp_last = cnt_w'((32'd1 << dec_i) - 32'd1);
  assign first    = (cnt_q == '0);
  assign last     = (cnt_q == grp_last);

  // sign extended running sum, restarts on the first sample
  always_comb begin
    acc_nxt = acc_w'(smp_i.sample);
    if (!first) begin
      acc_nxt = acc_q + acc_w'(smp_i.sample);
    end
  end

  assign avg_wide = acc_nxt >>> dec_i;

  //////////////////////////////////////////////////////////////////////
  // group control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt_q     <= '0;
      rec_vld_o <= 1'b0;
    end else begin
      if (take) begin
        cnt_q <= last ? '0 : cnt_q + 1'b1;
      end
      // new record wins over the one leaving
      if (take && last) begin
        rec_vld_o <= 1'b1;
      end else if (rec_rdy_i) begin
        rec_vld_o <= 1'b0;
      end
    end
  end

  // sum, first stamp and record payload
  always_ff @(posedge adc_clk) begin
    if (take) begin
      acc_q <= acc_nxt;
      if (first) begin
        ts_q <= smp_i.ts;
      end
      if (last) begin
        rec_o.avg <= avg_wide[adc_w-1:0];
        rec_o.ts  <= first ? smp_i.ts : ts_q;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_rec_stable: assert property (@(posedge adc_clk) disable iff (top_rst)
    rec_vld_o && !rec_rdy_i |=> rec_vld_o && $stable(rec_o));

endmodule: sample_decimator

// File: logic/sample_fifo.sv
//////////////////////////////////////////////////////////////////////
// synchronous FIFO of stamped samples
// push only write side, drops when full
// sticky overflow flag, valid/ready read side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sample_fifo import acq_pkg::*; #(
  // entries, power of two from 4 up
  parameter int unsigned fifo_depth = 16
)(
  // clock and reset
  input  logic     adc_clk,
  input  logic     top_rst,
  // write side
  input  stamped_t wr_i,
  input  logic     wr_vld_i,
  // read side
  output stamped_t rd_o,
  output logic     rd_vld_o,
  input  logic     rd_rdy_i,
  // status
  output logic     overflow_o
);

  localparam int unsigned ptr_w = $clog2(fifo_depth);
  localparam int unsigned cnt_w = ptr_w + 1;

  // storage
  stamped_t mem [fifo_depth];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;

  logic full;
  logic push;
  logic pop;

  // full is judged on the registered count
  assign full = (cnt_q == cnt_w'(fifo_depth));
  assign push = wr_vld_i && !full;
  assign pop  = rd_vld_o && rd_rdy_i;

  // head of the buffer
  assign rd_vld_o = (cnt_q != '0);
  assign rd_o     = mem[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////////////////////////

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // count moves only when one side acts alone
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // dropped word, held until reset
      if (wr_vld_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // write port
  always_ff @(posedge adc_clk) begin
    if (push) begin
      mem[wr_ptr_q] <= wr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_cnt_bound: assert property (@(posedge adc_clk) disable iff (top_rst)
    cnt_q <= cnt_w'(fifo_depth));

  // head must not move while the reader stalls
  a_rd_stable: assert property (@(posedge adc_clk) disable iff (top_rst)
    rd_vld_o && !rd_rdy_i |=> rd_vld_o && $stable(rd_o));

endmodule: sample_fifo

// File: sim.f
+incdir+tests
logic/acq_pkg.sv
logic/adc_frontend.sv
logic/sample_fifo.sv
logic/sample_decimator.sv
logic/acq_top.sv
tests/tb_acq_top.sv

// File: tests/tb_model.svh
//////////////////////////////////////////////////////////////////////
// testbench model of the acquisition channel
// LCG step and expected calibrated sample
// compare tasks for records and the overflow flag
//////////////////////////////////////////////////////////////////////

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32 bit LCG, full period constants
function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// pin word to calibrated sample with its stamp
function automatic stamped_t model_sample(input logic [15:0] pin, input cal_t cal,
                                          input ts_t ts);
  stamped_t           s;
  logic signed [13:0] raw;
  longint             v;
  // inverted offset binary, top bit kept as sign
  raw = {pin[15], ~pin[14:2]};
  // gain is fixed point, 2^14 is unity
  v = (longint'(raw) * longint'(cal.gain)) >>> 14;
  v = v + longint'(cal.offset);
  // clamp to 14 bit signed
  if (v > 8191) begin
    v = 8191;
  end else if (v < -8192) begin
    v = -8192;
  end
  s.sample = sample_t'(v);
  s.ts     = ts;
  return s;
endfunction

// one record against the model
task automatic check_rec(input rec_t got, input rec_t exp, input string what);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns: %s avg %0d ts %0d, expected avg %0d ts %0d", $time, what,
             $signed(got.avg), got.ts, $signed(exp.avg), exp.ts);
  end
endtask

// status flag against its expected level
task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

// File: tests/tb_acq_top.sv
//////////////////////////////////////////////////////////////////////
// testbench of the acquisition channel top level
// LCG stimulus on the falling edge, queue based scoreboard
// unity, calibration, decimation, stall and overflow tests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_acq_top import acq_pkg::*; ();

  localparam int   fifo_depth  = 16;
  localparam int   n_smp       = 64;
  localparam int   cap_limit   = 2000;
  localparam int   drain_limit = 2000;
  localparam int   quiet_max   = 40;
  localparam cal_t unity       = '{gain: gain_t'(gain_one), offset: '0};

  logic             adc_clk;
  logic             top_rst;
  logic [pin_w-1:0] adc_dat_i;
  logic             adc_vld_i;
  cal_t             cal_i;
  logic [1:0]       dec_i;
  rec_t             rec_o;
  logic             rec_vld_o;
  logic             rec_rdy_i;
  logic             overflow_o;

  // scoreboard state
  stamped_t    exp_q[$];
  ts_t         next_ts;
  logic [31:0] lcg_state = 32'h3973_9946;
  int          err_cnt   = 0;
  int          rec_cnt   = 0;
  int          test_cnt  = 0;
  int          fail_cnt  = 0;
  bit          timed_out = 1'b0;
  // overflow test, records may skip lost samples
  bit          sub_mode  = 1'b0;
  bit          sub_first = 1'b0;

  `include "tb_model.svh"

  acq_top dut_i (.*);

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // scoreboard
  //////////////////////////////////////////////////////////////////////

  // record accepted at the coming rising edge
  task automatic take_record();
    rec_t     exp;
    stamped_t s;
    longint   sum;
    int       n;
    n = 1 << dec_i;
    rec_cnt++;
    // lost samples are skipped, the first record may not skip
    if (sub_mode && !sub_first) begin
      while (exp_q.size() > 0 && exp_q[0].ts != rec_o.ts) begin
        void'(exp_q.pop_front());
      end
    end
    sub_first = 1'b0;
    if (exp_q.size() < n) begin
      err_cnt++;
      $display("record at %0t ns has no matching samples in the model", $time);
    end else begin
      exp.ts = exp_q[0].ts;
      sum = 0;
      repeat (n) begin
        s = exp_q.pop_front();
        sum += longint'(s.sample);
      end
      exp.avg = sample_t'(sum >>> dec_i);
      check_rec(rec_o, exp, "record");
    end
  endtask

  // one cycle, called and returning at a falling edge
  task automatic step(input logic vld, input logic [pin_w-1:0] dat, input logic rdy);
    adc_vld_i = vld;
    adc_dat_i = dat;
    rec_rdy_i = rdy;
    if (vld) begin
      exp_q.push_back(model_sample(dat, cal_i, next_ts));
    end
    if (rec_vld_o && rdy) begin
      take_record();
    end
    next_ts++;
    @(negedge adc_clk);
  endtask

  // rdy_mode 0 always ready, 1 single cycle stalls, 2 held low
  task automatic send(input int n, input bit full_rate, input int rdy_mode);
    int          cap;
    int          t;
    logic [31:0] r;
    logic [31:0] d;
    logic        vld;
    logic        rdy;
    cap = 0;
    t = 0;
    while (cap < n && t < cap_limit) begin
      r = next_rand();
      d = next_rand();
      vld = full_rate || r[30];
      rdy = (rdy_mode == 0) || (rdy_mode == 1 && (!rec_rdy_i || r[29:28] != 2'b00));
      step(vld, d[31:16], rdy);
      cap += int'(vld);
      t++;
    end
    if (cap < n) begin
      timed_out = 1'b1;
      $display("timeout: only %0d of %0d samples were captured", cap, n);
    end
  endtask

  // idle until every expected sample came out, or records stop in sub mode
  task automatic drain();
    int t;
    int quiet;
    int last_cnt;
    t = 0;
    quiet = 0;
    while (!timed_out && exp_q.size() > 0 && quiet < quiet_max) begin
      last_cnt = rec_cnt;
      step(1'b0, '0, 1'b1);
      quiet = (sub_mode && rec_cnt == last_cnt) ? quiet + 1 : 0;
      t++;
      if (t >= drain_limit) begin
        timed_out = 1'b1;
        $display("timeout: %0d expected samples never came out", exp_q.size());
      end
    end
    exp_q.delete();
  endtask

  // config only changes with nothing in flight
  task automatic run_batch(input cal_t cal, input logic [1:0] dec, input int n,
                           input bit full_rate, input int rdy_mode);
    cal_i = cal;
    dec_i = dec;
    send(n, full_rate, rdy_mode);
    drain();
  endtask

  task automatic report(input string name, input int err_before);
    test_cnt++;
    if (err_cnt != err_before || timed_out) begin
      fail_cnt++;
      $display("%-9s fail, %0d records, %0d errors", name, rec_cnt, err_cnt - err_before);
    end else begin
      $display("%-9s pass, %0d records", name, rec_cnt);
    end
    rec_cnt = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_cal();
    int          e;
    logic [31:0] r;
    cal_t        cal;
    e = err_cnt;
    for (int b = 0; b < 4; b++) begin
      r = next_rand();
      // both extremes, then random calibration
      case (b)
        0: cal = '{gain: 16'sh7fff, offset: 14'sh1fff};
        1: cal = '{gain: 16'sh8000, offset: 14'sh2000};
        default: cal = '{gain: gain_t'(r[31:16]), offset: sample_t'(r[15:2])};
      endcase
      run_batch(cal, 2'd0, n_smp / 2, 1'b0, 0);
    end
    report("cal", e);
  endtask

  task automatic test_overflow();
    int e;
    int t;
    e = err_cnt;
    cal_i = unity;
    dec_i = 2'd0;
    sub_mode = 1'b1;
    sub_first = 1'b1;
    send(fifo_depth + 8, 1'b1, 2);
    // dropped push lands a few cycles after the last capture
    t = 0;
    while (!overflow_o && t < 20) begin
      step(1'b0, '0, 1'b0);
      t++;
    end
    check_flag(overflow_o, 1'b1, "overflow_o with ready held low");
    drain();
    sub_mode = 1'b0;
    if (rec_cnt == 0) begin
      err_cnt++;
      $display("no record came out after ready returned");
    end
    report("overflow", e);
  endtask

  initial begin
    int e;
    top_rst   = 1'b1;
    adc_dat_i = '0;
    adc_vld_i = 1'b0;
    cal_i     = unity;
    dec_i     = 2'd0;
    rec_rdy_i = 1'b0;
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    top_rst = 1'b0;
    // cts reads 0 at the next rising edge
    next_ts = '0;

    e = err_cnt;
    run_batch(unity, 2'd0, n_smp, 1'b0, 0);
    report("unity", e);
    if (!timed_out) begin
      test_cal();
    end
    if (!timed_out) begin
      e = err_cnt;
      for (int d = 1; d <= 3; d++) begin
        run_batch(unity, d[1:0], n_smp, 1'b0, 0);
      end
      report("decimate", e);
    end
    if (!timed_out) begin
      e = err_cnt;
      run_batch(unity, 2'd0, n_smp, 1'b0, 1);
      check_flag(overflow_o, 1'b0, "overflow_o after short stalls");
      report("stall", e);
    end
    if (!timed_out) begin
      test_overflow();
    end

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (timed_out || err_cnt != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule: tb_acq_top
